/* sim.f */
common/loader_pkg.sv
common/pll_pkg.sv
loader/rom_map.sv
loader/prg_tracker.sv
loader/reg_inject.sv
verilog/write_router.sv
verilog/reconfig_seq.sv
verilog/load_top.sv
dv/tb_load_top.sv

/* dv/tb_load_top.sv */
`timescale 1ns/100ps

module tb_load_top import loader_pkg::*, pll_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int ROM_BYTES   = 24;
    localparam int PRG_LEN     = 3600;
    localparam int RAW_LEN     = 40;
    localparam int BUSY_CYCLES = 8;
    localparam addr_t LOAD_ADDR = 16'h1200;
    localparam int RUN_CYCLES  = 4 * (ROM_BYTES + HDR_LEN + PRG_LEN + RAW_LEN)
                                 + 4 * INJECT_LEN + 2 * RECONF_TIMEOUT + 1000;

    // Output port a write should land on
    localparam logic [1:0] DEST_CORE  = 2'd0;
    localparam logic [1:0] DEST_MEM   = 2'd1;
    localparam logic [1:0] DEST_DRIVE = 2'd2;

    typedef struct packed {
        logic [31:0] cyc;
        logic [1:0]  dest;
        addr_t       addr;
        byte_t       data;
    } exp_t;

    logic  clk_32;
    logic  rst_i      = 1'b1;
    logic  download_i = 1'b0;
    byte_t index_i    = '0;
    logic  wr_i       = 1'b0;
    addr_t addr_i     = '0;
    byte_t data_i     = '0;
    logic  raw_load_i = 1'b0;
    logic  ntsc_i     = 1'b0;
    logic  pll_busy_i = 1'b0;
    logic  core_we_o;
    logic  mem_we_o;
    logic  drive_we_o;
    addr_t wr_addr_o;
    byte_t wr_data_o;
    logic  force_reset_o;
    logic  pll_write_o;
    logic  pll_reconfig_o;
    logic  pll_reset_o;

    exp_t        exp_q[$];
    exp_t        got;
    int          cyc = 0;
    int          fall_cyc;
    int          force_cnt = 0;
    int          force_cyc = 0;
    int          write_cnt = 0;
    int          reconf_cnt = 0;
    int          reconf_cyc = 0;
    int          reset_cnt = 0;
    int          reset_cyc = 0;
    int          busy_cnt = 0;
    bit          write_seen = 1'b0;
    bit          reconf_seen = 1'b0;
    bit          busy_prev = 1'b0;
    bit          stick_busy = 1'b0;
    bit          stuck = 1'b0;
    logic [31:0] rng = 32'd89047;

    load_top dut (.*);

    initial begin
        clk_32 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_32 = ~clk_32;
    end

    always @(posedge clk_32) cyc <= cyc + 1;

    // ==================================================
    // Reference model and helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Returns 0 for image bytes that are thrown away
    function automatic bit rom_ref(input addr_t a, output addr_t tgt, output logic [1:0] dest);
        dest    = DEST_CORE;
        tgt     = '0;
        rom_ref = 1'b1;
        case (a[15:13])
            3'd0, 3'd1: begin
                dest = DEST_DRIVE;
                tgt  = {2'b00, a[13:0]};
            end
            3'd2, 3'd3: tgt = 16'hE000 + a[12:0];
            3'd4:       tgt = 16'hC000 + a[12:0];
            3'd5:       tgt = 16'h8000 + a[11:0];
            default:    rom_ref = 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] prg_dest(input addr_t a);
        if (a <= 16'h03FF || (a >= 16'h1000 && a <= 16'h1FFF) ||
            (a >= 16'h9400 && a <= 16'h97FF)) begin
            return DEST_CORE;
        end
        return DEST_MEM;
    endfunction

    // Even pointer slots carry the low byte of the end address
    function automatic byte_t pointer_byte(input addr_t end_a, input int i);
        return (i % 2 == 0) ? end_a[7:0] : end_a[15:8];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] val,
                               input logic [31:0] exp);
        if (val !== exp) begin
            abort_run($sformatf("** Error at %0t: %s = %h, expected %h",
                                $time, name, val, exp));
        end
    endtask

    // One host byte, four cycles per byte
    task automatic host_write(input addr_t a, input byte_t d, input bit want,
                              input logic [1:0] dest, input addr_t tgt);
        exp_t e;
        @(posedge clk_32);
        wr_i   <= 1'b1;
        addr_i <= a;
        data_i <= d;
        if (want) begin
            e.cyc  = cyc + 3;
            e.dest = dest;
            e.addr = tgt;
            e.data = d;
            exp_q.push_back(e);
        end
        @(posedge clk_32);
        wr_i <= 1'b0;
        repeat (2) @(posedge clk_32);
    endtask

    // Drops download and queues the eight zero page pointer writes
    task automatic end_program(input addr_t end_a);
        exp_t e;
        @(posedge clk_32);
        download_i <= 1'b0;
        fall_cyc = cyc + 1;
        for (int i = 0; i < 8; i++) begin
            e.cyc  = cyc + 4 + 2 * i;
            e.dest = prg_dest(INJECT_ADDRS[i]);
            e.addr = INJECT_ADDRS[i];
            e.data = pointer_byte(end_a, i);
            exp_q.push_back(e);
        end
    endtask

    task automatic wait_drain(input string what);
        int t = 0;
        while (exp_q.size() != 0 && t < 200) begin
            @(posedge clk_32);
            t++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("Timed out waiting for the %s writes", what));
        end
    endtask

    // ==================================================
    // Compare, monitors, busy model and watchdog
    // ==================================================
    always @(negedge clk_32) begin
        if (!rst_i && (core_we_o || mem_we_o || drive_we_o)) begin
            if (exp_q.size() == 0) begin
                abort_run("A write strobe came out with no write pending");
            end
            got = exp_q.pop_front();
            check_value("write cycle", cyc, got.cyc);
            check_value("core_we_o", core_we_o, got.dest == DEST_CORE);
            check_value("mem_we_o", mem_we_o, got.dest == DEST_MEM);
            check_value("drive_we_o", drive_we_o, got.dest == DEST_DRIVE);
            check_value("wr_addr_o", wr_addr_o, got.addr);
            check_value("wr_data_o", wr_data_o, got.data);
        end
    end

    always @(negedge clk_32) begin
        write_seen  = !rst_i && pll_write_o;
        reconf_seen = !rst_i && pll_reconfig_o;
        if (write_seen) begin
            write_cnt++;
        end
        if (reconf_seen) begin
            check_value("pll_busy_i at reconfigure", busy_prev, 0);
            reconf_cnt++;
            reconf_cyc = cyc;
        end
        if (!rst_i && pll_reset_o) begin
            reset_cnt++;
            reset_cyc = cyc;
        end
        if (!rst_i && force_reset_o) begin
            force_cnt++;
            force_cyc = cyc;
        end
        busy_prev = pll_busy_i;
    end

    // Generator busy after each rewrite and reconfigure, optionally stuck
    always @(posedge clk_32) begin
        if (write_seen || reconf_seen) begin
            busy_cnt   <= BUSY_CYCLES;
            pll_busy_i <= 1'b1;
            if (reconf_seen && stick_busy) begin
                stuck <= 1'b1;
            end
        end else if (stuck) begin
            pll_busy_i <= 1'b1;
        end else if (busy_cnt != 0) begin
            busy_cnt   <= busy_cnt - 1;
            pll_busy_i <= (busy_cnt > 1);
        end else begin
            pll_busy_i <= 1'b0;
        end
    end

    initial begin
        repeat (2 * RUN_CYCLES) @(posedge clk_32);
        abort_run("Watchdog expired before the test sequence finished");
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        addr_t       a;
        addr_t       tgt;
        logic [1:0]  dest;
        bit          hit;
        int          t;

        repeat (10) @(posedge clk_32);
        rst_i <= 1'b0;
        repeat (4) @(posedge clk_32);

        // ROM image, three random bytes in each of the eight regions
        index_i    <= 8'd0;
        download_i <= 1'b1;
        for (int r = 0; r < 8; r++) begin
            for (int j = 0; j < ROM_BYTES / 8; j++) begin
                rng = xorshift32(rng);
                a   = {r[2:0], rng[12:0]};
                hit = rom_ref(a, tgt, dest);
                host_write(a, rng[20:13], hit, dest, tgt);
            end
        end
        @(posedge clk_32);
        download_i <= 1'b0;
        wait_drain("ROM image");
        @(posedge clk_32);

        // Header program at $1200, runs past $1FFF into external memory
        index_i    <= 8'd1;
        download_i <= 1'b1;
        host_write(16'd0, LOAD_ADDR[7:0], 1'b0, DEST_CORE, '0);
        host_write(16'd1, LOAD_ADDR[15:8], 1'b0, DEST_CORE, '0);
        for (int k = 0; k < PRG_LEN; k++) begin
            rng = xorshift32(rng);
            a   = LOAD_ADDR + k;
            host_write(k + HDR_LEN, rng[7:0], 1'b1, prg_dest(a), a);
        end
        end_program(LOAD_ADDR + PRG_LEN - 1);
        wait_drain("header program pointer");
        while (cyc < fall_cyc + INJECT_LEN + 4) @(posedge clk_32);
        check_value("force_reset_o pulses", force_cnt, 0);

        // Raw program lands at $A000 and asks for a reset
        raw_load_i <= 1'b1;
        index_i    <= 8'd2;
        @(posedge clk_32);
        download_i <= 1'b1;
        for (int k = 0; k < RAW_LEN; k++) begin
            rng = xorshift32(rng);
            a   = 16'hA000 + k;
            host_write(k, rng[7:0], 1'b1, prg_dest(a), a);
        end
        end_program(16'hA000 + RAW_LEN - 1);
        wait_drain("raw program pointer");
        while (cyc < fall_cyc + INJECT_LEN + 4) @(posedge clk_32);
        check_value("force_reset_o pulses", force_cnt, 1);
        check_value("force_reset_o in window", force_cyc - fall_cyc <= INJECT_LEN + 2, 1);

        // Video standard change with a well behaved generator
        @(posedge clk_32);
        ntsc_i <= 1'b1;
        t = 0;
        while (reconf_cnt == 0 && t < 100) begin
            @(posedge clk_32);
            t++;
        end
        // Busy rises after the reconfigure pulse, then clears
        t = 0;
        while (!pll_busy_i && t < 100) begin
            @(posedge clk_32);
            t++;
        end
        t = 0;
        while (pll_busy_i && t < 100) begin
            @(posedge clk_32);
            t++;
        end
        repeat (4) @(posedge clk_32);
        check_value("pll_write_o pulses", write_cnt, 1);
        check_value("pll_reconfig_o pulses", reconf_cnt, 1);
        check_value("pll_reset_o pulses", reset_cnt, 0);

        // Change back, generator stays busy after reconfigure
        stick_busy <= 1'b1;
        ntsc_i     <= 1'b0;
        t = 0;
        while (reset_cnt == 0 && t < RECONF_TIMEOUT + 100) begin
            @(posedge clk_32);
            t++;
        end
        repeat (20) @(posedge clk_32);
        check_value("pll_write_o pulses", write_cnt, 2);
        check_value("pll_reconfig_o pulses", reconf_cnt, 2);
        check_value("pll_reset_o pulses", reset_cnt, 1);
        check_value("pll_reset_o delay", reset_cyc - reconf_cyc >= RECONF_TIMEOUT, 1);

        if (exp_q.size() != 0) begin
            abort_run("Writes were still pending at the end of the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* verilog/load_top.sv */
`timescale 1ns/100ps

module load_top import loader_pkg::*; (
    input  logic  clk_32,
    input  logic  rst_i,
    input  logic  download_i,
    input  byte_t index_i,
    input  logic  wr_i,
    input  addr_t addr_i,
    input  byte_t data_i,
    input  logic  raw_load_i,
    input  logic  ntsc_i,
    input  logic  pll_busy_i,
    output logic  core_we_o,
    output logic  mem_we_o,
    output logic  drive_we_o,
    output addr_t wr_addr_o,
    output byte_t wr_data_o,
    output logic  force_reset_o,
    output logic  pll_write_o,
    output logic  pll_reconfig_o,
    output logic  pll_reset_o
);

    logic  rom_wr;
    logic  prg_wr;
    logic  prg_active;
    logic  rom_we;
    addr_t rom_addr;
    byte_t rom_data;
    logic  rom_drive;
    logic  prg_we;
    addr_t prg_addr;
    byte_t prg_data;
    addr_t end_addr;
    logic  hit_base;
    logic  inj_we;
    addr_t inj_addr;
    byte_t inj_data;

    // Index 0 is the ROM image, anything else a program
    assign rom_wr     = wr_i && (index_i == '0);
    assign prg_wr     = wr_i && (index_i != '0);
    assign prg_active = download_i && (index_i != '0);

    rom_map u_rom_map (
        .clk_32, .rst_i, .rom_wr_i(rom_wr), .addr_i, .data_i,
        .rom_we_o(rom_we), .rom_addr_o(rom_addr), .rom_data_o(rom_data),
        .rom_drive_o(rom_drive)
    );

    prg_tracker u_prg_tracker (
        .clk_32, .rst_i, .prg_wr_i(prg_wr), .raw_load_i, .addr_i, .data_i,
        .prg_we_o(prg_we), .prg_addr_o(prg_addr), .prg_data_o(prg_data),
        .end_addr_o(end_addr), .hit_base_o(hit_base)
    );

    reg_inject u_reg_inject (
        .clk_32, .rst_i, .prg_active_i(prg_active), .end_addr_i(end_addr),
        .hit_base_i(hit_base), .inj_we_o(inj_we), .inj_addr_o(inj_addr),
        .inj_data_o(inj_data), .force_reset_o
    );

    write_router u_write_router (
        .clk_32, .rst_i,
        .rom_we_i(rom_we), .rom_addr_i(rom_addr), .rom_data_i(rom_data),
        .rom_drive_i(rom_drive),
        .prg_we_i(prg_we), .prg_addr_i(prg_addr), .prg_data_i(prg_data),
        .inj_we_i(inj_we), .inj_addr_i(inj_addr), .inj_data_i(inj_data),
        .core_we_o, .mem_we_o, .drive_we_o, .wr_addr_o, .wr_data_o
    );

    reconfig_seq u_reconfig_seq (
        .clk_32, .rst_i, .ntsc_i, .pll_busy_i,
        .pll_write_o, .pll_reconfig_o, .pll_reset_o
    );

endmodule

/* verilog/reconfig_seq.sv */
`timescale 1ns/100ps

module reconfig_seq import pll_pkg::*; (
    input  logic clk_32,
    input  logic rst_i,
    input  logic ntsc_i,
    input  logic pll_busy_i,
    output logic pll_write_o,
    output logic pll_reconfig_o,
    output logic pll_reset_o
);

    reconf_state_t           state;
    logic                    ntsc_s1;
    logic                    ntsc_s2;
    logic                    ntsc_last;
    logic [RECONF_CNT_W-1:0] timeout_cnt;

    // ==================================================
    // Standard change sequencer
    // ==================================================
    always_ff @(posedge clk_32) begin
        if (rst_i) begin
            // PLL starts in PAL, so NTSC at reset triggers a retune
            ntsc_s1        <= 1'b0;
            ntsc_s2        <= 1'b0;
            ntsc_last      <= 1'b0;
            state          <= IDLE;
            timeout_cnt    <= '0;
            pll_write_o    <= 1'b0;
            pll_reconfig_o <= 1'b0;
            pll_reset_o    <= 1'b0;
        end else begin
            ntsc_s1        <= ntsc_i;
            ntsc_s2        <= ntsc_s1;
            pll_write_o    <= 1'b0;
            pll_reconfig_o <= 1'b0;
            pll_reset_o    <= 1'b0;
            case (state)
                IDLE: begin
                    ntsc_last <= ntsc_s2;
                    if (ntsc_s2 != ntsc_last) begin
                        pll_write_o <= 1'b1;
                        state       <= LOAD;
                    end
                end
                LOAD: begin
                    state <= WAIT_IDLE;
                end
                WAIT_IDLE: begin
                    if (!pll_busy_i) begin
                        pll_reconfig_o <= 1'b1;
                        timeout_cnt    <= RECONF_CNT_W'(RECONF_TIMEOUT);
                        state          <= RUN;
                    end
                end
                RUN: begin
                    timeout_cnt <= timeout_cnt - 1'b1;
                    if (!pll_reconfig_o && !pll_busy_i) begin
                        state <= IDLE;
                    end else if (timeout_cnt == RECONF_CNT_W'(1)) begin
                        // Generator stuck busy, kick its reset
                        pll_reset_o <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Reconfigure is only issued into an idle generator
    assert property (@(posedge clk_32) disable iff (rst_i)
        $rose(pll_reconfig_o) |-> !pll_busy_i)
        else $error("reconfig_seq: reconfigure raised while busy");

endmodule

/* verilog/write_router.sv */
`timescale 1ns/100ps

module write_router import loader_pkg::*; (
    input  logic  clk_32,
    input  logic  rst_i,
    input  logic  rom_we_i,
    input  addr_t rom_addr_i,
    input  byte_t rom_data_i,
    input  logic  rom_drive_i,
    input  logic  prg_we_i,
    input  addr_t prg_addr_i,
    input  byte_t prg_data_i,
    input  logic  inj_we_i,
    input  addr_t inj_addr_i,
    input  byte_t inj_data_i,
    output logic  core_we_o,
    output logic  mem_we_o,
    output logic  drive_we_o,
    output addr_t wr_addr_o,
    output byte_t wr_data_o
);

    addr_t sel_addr;
    byte_t sel_data;
    logic  ram_we;
    logic  internal;

    assign ram_we = prg_we_i || inj_we_i;

    always_comb begin
        if (rom_we_i) begin
            sel_addr = rom_addr_i;
            sel_data = rom_data_i;
        end else if (inj_we_i) begin
            sel_addr = inj_addr_i;
            sel_data = inj_data_i;
        end else begin
            sel_addr = prg_addr_i;
            sel_data = prg_data_i;
        end
    end

    // Core RAM windows, rest goes to external memory
    assign internal = (sel_addr >= INT0_LO && sel_addr <= INT0_HI) ||
                      (sel_addr >= INT1_LO && sel_addr <= INT1_HI) ||
                      (sel_addr >= INT2_LO && sel_addr <= INT2_HI);

    always_ff @(posedge clk_32) begin
        if (rst_i) begin
            core_we_o  <= 1'b0;
            mem_we_o   <= 1'b0;
            drive_we_o <= 1'b0;
            wr_addr_o  <= '0;
            wr_data_o  <= '0;
        end else begin
            core_we_o  <= (rom_we_i && !rom_drive_i) || (ram_we && internal);
            mem_we_o   <= ram_we && !internal;
            drive_we_o <= rom_we_i && rom_drive_i;
            if (rom_we_i || ram_we) begin
                wr_addr_o <= sel_addr;
                wr_data_o <= sel_data;
            end
        end
    end

    // Loader blocks take turns, never two strobes at once
    assert property (@(posedge clk_32) disable iff (rst_i)
        $onehot0({rom_we_i, prg_we_i, inj_we_i}))
        else $error("write_router: colliding write strobes");

endmodule

/* loader/reg_inject.sv */
`timescale 1ns/100ps

module reg_inject import loader_pkg::*; (
    input  logic  clk_32,
    input  logic  rst_i,
    input  logic  prg_active_i,
    input  addr_t end_addr_i,
    input  logic  hit_base_i,
    output logic  inj_we_o,
    output addr_t inj_addr_o,
    output byte_t inj_data_o,
    output logic  force_reset_o
);

    logic                    active_d;
    logic                    prg_fall;
    logic                    inj_slot;
    logic [INJECT_CNT_W-1:0] seq_cnt;

    assign prg_fall = active_d && !prg_active_i;

    // Odd counts in the first half carry the eight pointer writes
    assign inj_slot = seq_cnt[0] && !seq_cnt[INJECT_CNT_W-1];

    // ==================================================
    // Injection sequence
    // ==================================================
    always_ff @(posedge clk_32) begin
        if (rst_i) begin
            active_d      <= 1'b0;
            seq_cnt       <= '0;
            inj_we_o      <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            active_d      <= prg_active_i;
            inj_we_o      <= inj_slot;
            force_reset_o <= 1'b0;
            if (prg_fall) begin
                seq_cnt <= INJECT_CNT_W'(1);
            end else if (seq_cnt != '0) begin
                // Wraps back to zero after the last count
                seq_cnt <= seq_cnt + 1'b1;
            end
            if (seq_cnt == INJECT_CNT_W'(INJECT_LEN - 1)) begin
                force_reset_o <= hit_base_i;
            end
        end
    end

    // Even pointer entries take the low byte, odd ones the high byte
    always_ff @(posedge clk_32) begin
        if (inj_slot) begin
            inj_addr_o <= INJECT_ADDRS[seq_cnt[3:1]];
            inj_data_o <= seq_cnt[1] ? end_addr_i[15:8] : end_addr_i[7:0];
        end
    end

    // Host must not finish another download while pointers are patched
    assert property (@(posedge clk_32) disable iff (rst_i)
        (seq_cnt != '0) |-> !prg_fall)
        else $error("reg_inject: sequence restarted at count %0d", seq_cnt);

endmodule

/* loader/prg_tracker.sv */
`timescale 1ns/100ps

module prg_tracker import loader_pkg::*; (
    input  logic  clk_32,
    input  logic  rst_i,
    input  logic  prg_wr_i,
    input  logic  raw_load_i,
    input  addr_t addr_i,
    input  byte_t data_i,
    output logic  prg_we_o,
    output addr_t prg_addr_o,
    output byte_t prg_data_o,
    output addr_t end_addr_o,
    output logic  hit_base_o
);

    addr_t next_addr;
    addr_t target;
    logic  first_byte;
    logic  hdr_byte;

    assign first_byte = (addr_i == '0);
    assign hdr_byte   = !raw_load_i && (addr_i < addr_t'(HDR_LEN));

    // Raw images have no header and start at the fixed base
    assign target = (raw_load_i && first_byte) ? RAW_LOAD_BASE : next_addr;

    // ==================================================
    // Load address tracking
    // ==================================================
    always_ff @(posedge clk_32) begin
        if (rst_i) begin
            prg_we_o   <= 1'b0;
            next_addr  <= '0;
            end_addr_o <= '0;
            hit_base_o <= 1'b0;
        end else begin
            prg_we_o <= 1'b0;
            if (prg_wr_i) begin
                // Byte 0 marks a new download
                if (first_byte) begin
                    hit_base_o <= 1'b0;
                end
                if (hdr_byte) begin
                    if (first_byte) begin
                        next_addr[7:0] <= data_i;
                    end else begin
                        next_addr[15:8] <= data_i;
                    end
                end else begin
                    prg_we_o   <= 1'b1;
                    next_addr  <= target + 16'd1;
                    end_addr_o <= target;
                    // Cartridge image at $A000 needs a restart to run
                    if (target == RAW_LOAD_BASE) begin
                        hit_base_o <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_32) begin
        if (prg_wr_i) begin
            prg_addr_o <= target;
            prg_data_o <= data_i;
        end
    end

endmodule

/* loader/rom_map.sv */
`timescale 1ns/100ps

module rom_map import loader_pkg::*; (
    input  logic  clk_32,
    input  logic  rst_i,
    input  logic  rom_wr_i,
    input  addr_t addr_i,
    input  byte_t data_i,
    output logic  rom_we_o,
    output addr_t rom_addr_o,
    output byte_t rom_data_o,
    output logic  rom_drive_o
);

    logic  hit;
    logic  drive;
    addr_t target;

    // Region decode on the top three image address bits
    always_comb begin
        hit    = 1'b1;
        drive  = 1'b0;
        target = '0;
        case (addr_i[15:13])
            RGN_DRIVE_LO, RGN_DRIVE_HI: begin
                drive  = 1'b1;
                target = DRIVE_ROM_BASE | {2'b00, addr_i[13:0]};
            end
            // Both kernal variants share one slot
            RGN_KERNAL_PAL, RGN_KERNAL_NTSC: begin
                target = KERNAL_BASE | {3'b000, addr_i[12:0]};
            end
            RGN_BASIC: begin
                target = BASIC_BASE | {3'b000, addr_i[12:0]};
            end
            RGN_CHAR: begin
                target = CHAR_BASE | {4'b0000, addr_i[11:0]};
            end
            default: begin
                // Top 16K of the image is thrown away
                hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_32) begin
        if (rst_i) begin
            rom_we_o <= 1'b0;
        end else begin
            rom_we_o <= rom_wr_i && hit;
        end
    end

    always_ff @(posedge clk_32) begin
        if (rom_wr_i) begin
            rom_addr_o  <= target;
            rom_data_o  <= data_i;
            rom_drive_o <= drive;
        end
    end

endmodule

/* common/pll_pkg.sv */
package pll_pkg;

    // ==================================================
    // Video clock reconfiguration
    // ==================================================

    // Cycles allowed for busy to drop after reconfigure
    localparam int RECONF_TIMEOUT = 1000;
    localparam int RECONF_CNT_W   = $clog2(RECONF_TIMEOUT + 1);

    typedef enum logic [1:0] {
        // Watching the synchronized standard select
        IDLE,
        // Parameter store rewrite in flight
        LOAD,
        // Holding reconfigure until the generator is free
        WAIT_IDLE,
        // Reconfigure issued, waiting for busy to clear
        RUN
    } reconf_state_t;

endpackage

/* common/loader_pkg.sv */
package loader_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;

    // ==================================================
    // ROM image regions, keyed by image address [15:13]
    // ==================================================
    localparam logic [2:0] RGN_DRIVE_LO    = 3'b000;
    localparam logic [2:0] RGN_DRIVE_HI    = 3'b001;
    localparam logic [2:0] RGN_KERNAL_PAL  = 3'b010;
    localparam logic [2:0] RGN_KERNAL_NTSC = 3'b011;
    localparam logic [2:0] RGN_BASIC       = 3'b100;
    localparam logic [2:0] RGN_CHAR        = 3'b101;

    // Target base of each region
    localparam addr_t DRIVE_ROM_BASE = 16'h0000;
    localparam addr_t KERNAL_BASE    = 16'hE000;
    localparam addr_t BASIC_BASE     = 16'hC000;
    localparam addr_t CHAR_BASE      = 16'h8000;

    // ==================================================
    // Program loading
    // ==================================================
    localparam addr_t RAW_LOAD_BASE = 16'hA000;
    // Load address header, low byte first
    localparam int HDR_LEN = 2;

    // Core-internal RAM windows, everything else is external
    localparam addr_t INT0_LO = 16'h0000;
    localparam addr_t INT0_HI = 16'h03FF;
    localparam addr_t INT1_LO = 16'h1000;
    localparam addr_t INT1_HI = 16'h1FFF;
    localparam addr_t INT2_LO = 16'h9400;
    localparam addr_t INT2_HI = 16'h97FF;

    // Zero page pointers patched with the end address
    localparam addr_t INJECT_ADDRS [8] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };
    localparam int INJECT_LEN   = 32;
    localparam int INJECT_CNT_W = $clog2(INJECT_LEN);

endpackage
